// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the decode stage simulation with Verilator

set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f verilog.f --top-module tb_inst_decode -Mdir obj_dir; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_inst_decode)
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1

// ==== test/id_trace.txt ====
# test ibus_valid ibus_rddata if_valid pc ex_we ex_waddr ex_wrdata ex_is_load wb_we wb_waddr wb_wrdata
#   ready flush | exp_ready_o exp_valid exp_rddata0 exp_rddata1 exp_delayslot exp_mem_vaddr
1 1 00201821 1 00400000 0 00 00000000 0 1 01 00001111 1 0 1 1 00001111 00000000 0 00002932
1 1 00222021 1 00400004 0 00 00000000 0 1 02 22220000 1 0 1 1 00001111 22220000 0 00003132
1 1 00412821 1 00400008 0 00 00000000 0 0 00 00000000 1 0 1 1 22220000 00001111 0 22222821
1 1 00013021 1 0040000c 0 00 00000000 0 1 00 deadbeef 1 0 1 1 00000000 00001111 0 00003021
2 1 2428fff0 1 00400010 0 00 00000000 0 0 00 00000000 1 0 1 1 00001111 fffffff0 0 00001101
2 1 34498001 1 00400014 0 00 00000000 0 0 00 00000000 1 0 1 1 22220000 00008001 0 22218001
2 1 8c4afffc 1 00400018 0 00 00000000 0 0 00 00000000 1 0 1 1 22220000 fffffffc 0 2221fffc
2 1 ac410010 1 0040001c 0 00 00000000 0 0 00 00000000 1 0 1 1 22220000 00001111 0 22220010
3 1 00211821 1 00400020 1 01 aaaa0000 0 1 01 bbbb0000 1 0 1 1 aaaa0000 aaaa0000 0 aaaa1821
3 1 00222021 1 00400024 1 02 12345678 0 1 02 22220000 1 0 1 1 bbbb0000 12345678 0 bbbb2021
4 1 00222821 1 00400028 1 01 00000000 1 0 00 00000000 1 0 0 0 00000000 00000000 0 00000000
4 1 ffffffff 1 00400028 1 01 00000000 1 0 00 00000000 1 0 0 0 00000000 00000000 0 00000000
4 1 ffffffff 1 00400028 0 00 00000000 0 1 01 0000cafe 1 0 1 1 0000cafe 22220000 0 0000f31f
5 1 10220004 1 0040002c 0 00 00000000 0 0 00 00000000 1 0 1 1 0000cafe 22220000 0 0000cb02
5 1 24060001 1 00400030 0 00 00000000 0 0 00 00000000 1 0 1 1 00000000 00000001 1 00000001
5 1 24070002 1 00400034 0 00 00000000 0 0 00 00000000 1 0 1 1 00000000 00000002 0 00000002
5 1 10220004 1 00400038 0 00 00000000 0 0 00 00000000 1 0 1 1 0000cafe 22220000 0 0000cb02
5 1 24060001 1 0040003c 0 00 00000000 0 0 00 00000000 1 1 1 0 00000000 00000000 0 00000000
5 1 24070002 1 00400040 0 00 00000000 0 0 00 00000000 1 0 1 1 00000000 00000002 0 00000002
6 1 24080055 1 00400044 0 00 00000000 0 0 00 00000000 1 0 1 1 00000000 00000055 0 00000055
6 1 24090066 1 00400048 0 00 00000000 0 0 00 00000000 0 0 0 1 00000000 00000055 0 00000055
6 1 24090066 1 00400048 0 00 00000000 0 0 00 00000000 1 0 1 1 00000000 00000066 0 00000066

// ==== test/tb_inst_decode.sv ====
// decode stage testbench
`timescale 1ns/1ps

module tb_inst_decode;
    import id_pkg::*;

    // one trace line, stimulus then expected registered outputs
    typedef struct packed {
        logic [7:0] test_id;
        logic       ibus_valid;
        uint32_t    ibus_rddata;
        pipe_if_t   pif;
        pipe_ex_t   pex;
        pipe_wb_t   pwb;
        logic       ready;
        logic       flush;
        logic       exp_ready;
        logic       exp_valid;
        uint32_t    exp_rd0;
        uint32_t    exp_rd1;
        logic       exp_ds;
        virt_t      exp_vaddr;
    } step_t;

    logic        clk;
    logic        rst;
    logic        ibus_valid;
    uint32_t     ibus_rddata;
    pipe_if_t    pipe_if;
    logic        ready_i;
    logic        ready_o;
    except_req_t except_req;
    pipe_id_t    pipe_id_n;
    pipe_id_t    pipe_id;
    pipe_ex_t    pipe_ex;
    pipe_wb_t    pipe_wb;

    step_t steps[$];
    int    errors = 0;
    int    test_errors = 0;
    int    tests_run = 0;
    int    tests_bad = 0;
    int    cycles = 0;
    int    limit = 200;

    inst_decode i_dut (
        .clk           (clk),
        .rst           (rst),
        .ibus_valid_i  (ibus_valid),
        .ibus_rddata_i (ibus_rddata),
        .ready_i       (ready_i),
        .ready_o       (ready_o),
        .except_req_i  (except_req),
        .pipe_if_i     (pipe_if),
        .pipe_id_n_o   (pipe_id_n),
        .pipe_id_o     (pipe_id),
        .pipe_ex_i     (pipe_ex),
        .pipe_wb_i     (pipe_wb)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // guard against a stuck run
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= limit) begin
            $display("timeout: run went past %0d cycles", limit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    task automatic load_trace();
        int          fd;
        int          cnt;
        string       line;
        logic [31:0] f [20];
        step_t       s;
        fd = $fopen("test/id_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file test/id_trace.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            cnt = $fgets(line, fd);
            if (cnt <= 0 || line.len() < 2 || line[0] == "#") begin
                continue;
            end
            cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19]);
            if (cnt != 20) begin
                $display("trace line could not be parsed: %s", line);
                errors++;
                continue;
            end
            s.test_id = f[0][7:0];
            s.ibus_valid = f[1][0];
            s.ibus_rddata = f[2];
            s.pif.valid = f[3][0];
            s.pif.pc = f[4];
            s.pex.regs_wreq.we = f[5][0];
            s.pex.regs_wreq.waddr = f[6][4:0];
            s.pex.regs_wreq.wrdata = f[7];
            s.pex.is_load = f[8][0];
            s.pwb.regs_wreq.we = f[9][0];
            s.pwb.regs_wreq.waddr = f[10][4:0];
            s.pwb.regs_wreq.wrdata = f[11];
            s.ready = f[12][0];
            s.flush = f[13][0];
            s.exp_ready = f[14][0];
            s.exp_valid = f[15][0];
            s.exp_rd0 = f[16];
            s.exp_rd1 = f[17];
            s.exp_ds = f[18][0];
            s.exp_vaddr = f[19];
            steps.push_back(s);
        end
        $fclose(fd);
    endtask

    task automatic drive_idle();
        ibus_valid = 1'b0;
        ibus_rddata = '0;
        pipe_if = '0;
        ready_i = 1'b0;
        except_req = '0;
        pipe_ex = '0;
        pipe_wb = '0;
    endtask

    task automatic apply_step(input step_t s);
        ibus_valid = s.ibus_valid;
        ibus_rddata = s.ibus_rddata;
        pipe_if = s.pif;
        pipe_ex = s.pex;
        pipe_wb = s.pwb;
        ready_i = s.ready;
        except_req.valid = s.flush;
    endtask

    task automatic report_mismatch(input int k, input string name,
                                   input logic [31:0] got, input logic [31:0] exp);
        $display("ERR step %0d %s got %h expected %h", k, name, got, exp);
        errors++;
        test_errors++;
    endtask

    // bundle ahead of the edge, taken only when execute accepts it
    task automatic verify_next_bundle(input int k);
        if (pipe_id_n.valid !== steps[k].exp_valid) begin
            report_mismatch(k, "pipe_id_n_o.valid", 32'(pipe_id_n.valid),
                32'(steps[k].exp_valid));
        end
        if (pipe_id_n.delayslot !== steps[k].exp_ds) begin
            report_mismatch(k, "pipe_id_n_o.delayslot", 32'(pipe_id_n.delayslot),
                32'(steps[k].exp_ds));
        end
        if (steps[k].exp_valid) begin
            if (pipe_id_n.regs_rddata0 !== steps[k].exp_rd0) begin
                report_mismatch(k, "pipe_id_n_o.regs_rddata0", pipe_id_n.regs_rddata0,
                    steps[k].exp_rd0);
            end
            if (pipe_id_n.regs_rddata1 !== steps[k].exp_rd1) begin
                report_mismatch(k, "pipe_id_n_o.regs_rddata1", pipe_id_n.regs_rddata1,
                    steps[k].exp_rd1);
            end
            if (pipe_id_n.mem_vaddr !== steps[k].exp_vaddr) begin
                report_mismatch(k, "pipe_id_n_o.mem_vaddr", pipe_id_n.mem_vaddr,
                    steps[k].exp_vaddr);
            end
            // fetch info rides along unchanged
            if (pipe_id_n.inst_fetch.pc !== steps[k].pif.pc) begin
                report_mismatch(k, "pipe_id_n_o.inst_fetch.pc", pipe_id_n.inst_fetch.pc,
                    steps[k].pif.pc);
            end
        end
    endtask

    // operands matter on a valid instruction and on a flushed, all-zero bundle
    task automatic check_registered(input int k);
        if (pipe_id.valid !== steps[k].exp_valid) begin
            report_mismatch(k, "pipe_id_o.valid", 32'(pipe_id.valid), 32'(steps[k].exp_valid));
        end
        if (pipe_id.delayslot !== steps[k].exp_ds) begin
            report_mismatch(k, "pipe_id_o.delayslot", 32'(pipe_id.delayslot),
                32'(steps[k].exp_ds));
        end
        if (steps[k].exp_valid || steps[k].flush) begin
            if (pipe_id.regs_rddata0 !== steps[k].exp_rd0) begin
                report_mismatch(k, "pipe_id_o.regs_rddata0", pipe_id.regs_rddata0,
                    steps[k].exp_rd0);
            end
            if (pipe_id.regs_rddata1 !== steps[k].exp_rd1) begin
                report_mismatch(k, "pipe_id_o.regs_rddata1", pipe_id.regs_rddata1,
                    steps[k].exp_rd1);
            end
            if (pipe_id.mem_vaddr !== steps[k].exp_vaddr) begin
                report_mismatch(k, "pipe_id_o.mem_vaddr", pipe_id.mem_vaddr, steps[k].exp_vaddr);
            end
        end
    endtask

    initial begin
        rst = 1'b1;
        drive_idle();
        load_trace();
        limit = steps.size() * 2 + 20;
        if (steps.size() == 0) begin
            $display("trace file holds no steps");
            errors++;
        end
        repeat (8) @(negedge clk);
        rst = 1'b0;
        for (int k = 0; k < steps.size(); k++) begin
            apply_step(steps[k]);
            #1;
            if (ready_o !== steps[k].exp_ready) begin
                report_mismatch(k, "ready_o", 32'(ready_o), 32'(steps[k].exp_ready));
            end
            if (steps[k].ready && !steps[k].flush) begin
                verify_next_bundle(k);
            end
            @(negedge clk);
            check_registered(k);
            if (k == steps.size() - 1 || steps[k + 1].test_id != steps[k].test_id) begin
                tests_run++;
                if (test_errors != 0) begin
                    tests_bad++;
                end
                $display("test %0d done with %0d errors", steps[k].test_id, test_errors);
                test_errors = 0;
            end
        end
        drive_idle();
        $display("tests run %0d, tests with errors %0d, errors %0d",
            tests_run, tests_bad, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
verilog/id_pkg.sv
verilog/decoder.sv
verilog/regfile.sv
verilog/regs_forward.sv
verilog/resolve_delayslot.sv
verilog/inst_decode.sv
test/tb_inst_decode.sv

// ==== verilog/decoder.sv ====
// instruction decoder
`timescale 1ns/1ps

module decoder (
    input  id_pkg::uint32_t       inst_i,
    output id_pkg::decoder_resp_t decoder_resp_o
);
    import id_pkg::*;

    inst_t         inst;
    decoder_resp_t resp;

    assign inst = inst_i;

    always_comb begin
        resp = '0;
        resp.alu_op = ALU_PASS;
        case (inst.i_form.opcode)
            OP_SPECIAL: begin
                resp.rs1 = inst.r_form.rs;
                resp.rs2 = inst.r_form.rt;
                resp.rd = inst.r_form.rd;
                resp.we = 1'b1;
                // shift amount must be zero for this subset
                resp.valid_inst = (inst.r_form.shamt == '0);
                case (inst.r_form.funct)
                    FN_ADDU: resp.alu_op = ALU_ADD;
                    FN_SUBU: resp.alu_op = ALU_SUB;
                    FN_AND:  resp.alu_op = ALU_AND;
                    FN_OR:   resp.alu_op = ALU_OR;
                    FN_XOR:  resp.alu_op = ALU_XOR;
                    FN_SLT:  resp.alu_op = ALU_SLT;
                    FN_JR: begin
                        resp.rs2 = '0;
                        resp.rd = '0;
                        resp.we = 1'b0;
                        resp.is_branch = 1'b1;
                    end
                    default: resp.valid_inst = 1'b0;
                endcase
            end
            OP_ADDIU, OP_LW: begin
                resp.rs1 = inst.i_form.rs;
                resp.rd = inst.i_form.rt;
                resp.we = 1'b1;
                resp.use_imm = 1'b1;
                resp.imm_signed = 1'b1;
                resp.alu_op = ALU_ADD;
                resp.is_load = (inst.i_form.opcode == OP_LW);
                resp.valid_inst = 1'b1;
            end
            OP_ANDI, OP_ORI, OP_XORI: begin
                resp.rs1 = inst.i_form.rs;
                resp.rd = inst.i_form.rt;
                resp.we = 1'b1;
                resp.use_imm = 1'b1;
                resp.valid_inst = 1'b1;
                case (inst.i_form.opcode)
                    OP_ANDI: resp.alu_op = ALU_AND;
                    OP_ORI:  resp.alu_op = ALU_OR;
                    default: resp.alu_op = ALU_XOR;
                endcase
            end
            OP_SW: begin
                // operand B carries the store data, address goes via mem_vaddr
                resp.rs1 = inst.i_form.rs;
                resp.rs2 = inst.i_form.rt;
                resp.is_store = 1'b1;
                resp.valid_inst = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                resp.rs1 = inst.i_form.rs;
                resp.rs2 = inst.i_form.rt;
                resp.alu_op = ALU_SUB;
                resp.is_branch = 1'b1;
                resp.valid_inst = 1'b1;
            end
            OP_J: begin
                resp.is_branch = 1'b1;
                resp.valid_inst = 1'b1;
            end
            default: resp.valid_inst = 1'b0;
        endcase
        // nothing unknown may write back
        if (!resp.valid_inst) begin
            resp.we = 1'b0;
        end
    end

    assign decoder_resp_o = resp;

endmodule

// ==== verilog/id_pkg.sv ====
// instruction decode types
package id_pkg;

    typedef logic [31:0] uint32_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [31:0] virt_t;

    // register-format view
    typedef struct packed {
        logic [5:0] opcode;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_form_t;

    // immediate-format view
    typedef struct packed {
        logic [5:0]  opcode;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm16;
    } i_form_t;

    typedef union packed {
        r_form_t r_form;
        i_form_t i_form;
    } inst_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS
    } alu_op_t;

    typedef struct packed {
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        logic      we;
        alu_op_t   alu_op;
        logic      use_imm;
        logic      imm_signed;
        logic      is_load;
        logic      is_store;
        logic      is_branch;
        logic      valid_inst;
    } decoder_resp_t;

    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        uint32_t   wrdata;
    } regs_wreq_t;

    typedef struct packed {
        logic  valid;
        virt_t pc;
    } pipe_if_t;

    typedef struct packed {
        regs_wreq_t regs_wreq;
        logic       is_load;
    } pipe_ex_t;

    typedef struct packed {
        regs_wreq_t regs_wreq;
    } pipe_wb_t;

    typedef struct packed {
        logic valid;
    } except_req_t;

    typedef struct packed {
        logic          valid;
        uint32_t       regs_rddata0;
        uint32_t       regs_rddata1;
        decoder_resp_t decode_resp;
        logic          delayslot;
        pipe_if_t      inst_fetch;
        virt_t         mem_vaddr;
    } pipe_id_t;

    // primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // funct codes under OP_SPECIAL
    localparam logic [5:0] FN_JR   = 6'h08;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;

endpackage

// ==== verilog/inst_decode.sv ====
// instruction decode stage
`timescale 1ns/1ps

module inst_decode (
    input  logic                clk,
    input  logic                rst,
    // fetch side
    input  logic                ibus_valid_i,
    input  id_pkg::uint32_t     ibus_rddata_i,
    input  id_pkg::pipe_if_t    pipe_if_i,
    // handshake levels
    input  logic                ready_i,
    output logic                ready_o,
    input  id_pkg::except_req_t except_req_i,
    // toward execute
    output id_pkg::pipe_id_t    pipe_id_n_o,
    output id_pkg::pipe_id_t    pipe_id_o,
    // bypass sources
    input  id_pkg::pipe_ex_t    pipe_ex_i,
    input  id_pkg::pipe_wb_t    pipe_wb_i
);
    import id_pkg::*;

    logic                  hold_stall;
    logic                  inst_saved_q;
    uint32_t               inst_save_q;
    uint32_t               fetch_word;
    inst_t                 inst;
    decoder_resp_t         decoder_resp;
    reg_addr_t       [1:0] regs_raddr;
    uint32_t         [1:0] regs_rddata;
    uint32_t         [1:0] fwd_rddata;
    logic                  load_stall;
    logic                  delayslot;
    uint32_t               imm_sext;
    uint32_t               imm_zext;

    // stage cannot take the next word this cycle
    assign hold_stall = !ready_o;

    // remember the word if fetch delivers it mid-stall
    always_ff @(posedge clk) begin
        if (rst || except_req_i.valid || !hold_stall) begin
            inst_saved_q <= 1'b0;
        end else if (ibus_valid_i) begin
            inst_saved_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (hold_stall && ibus_valid_i && !inst_saved_q) begin
            inst_save_q <= ibus_rddata_i;
        end
    end

    assign fetch_word = inst_saved_q ? inst_save_q : ibus_rddata_i;
    assign inst = fetch_word;

    decoder i_decoder (
        .inst_i         (fetch_word),
        .decoder_resp_o (decoder_resp)
    );

    assign regs_raddr = {decoder_resp.rs2, decoder_resp.rs1};

    regfile i_regfile (
        .clk           (clk),
        .rst           (rst),
        .regs_wreq_i   (pipe_wb_i.regs_wreq),
        .regs_raddr_i  (regs_raddr),
        .regs_rddata_o (regs_rddata)
    );

    regs_forward i_regs_forward (
        .regs_raddr_i  (regs_raddr),
        .regs_rddata_i (regs_rddata),
        .pipe_ex_i     (pipe_ex_i),
        .pipe_wb_i     (pipe_wb_i),
        .regs_rddata_o (fwd_rddata),
        .stall_o       (load_stall)
    );

    resolve_delayslot i_resolve_delayslot (
        .clk           (clk),
        .rst           (rst),
        .flush_i       (except_req_i.valid),
        .stall_i       (!ready_i),
        .issue_valid_i (pipe_id_n_o.valid),
        .is_branch_i   (decoder_resp.is_branch),
        .delayslot_o   (delayslot)
    );

    // immediate extension
    assign imm_sext = {{16{inst.i_form.imm16[15]}}, inst.i_form.imm16};
    assign imm_zext = {16'h0000, inst.i_form.imm16};

    always_comb begin
        pipe_id_n_o = '0;
        pipe_id_n_o.valid = pipe_if_i.valid && ibus_valid_i && !load_stall;
        pipe_id_n_o.regs_rddata0 = fwd_rddata[0];
        if (decoder_resp.use_imm) begin
            pipe_id_n_o.regs_rddata1 = decoder_resp.imm_signed ? imm_sext : imm_zext;
        end else begin
            pipe_id_n_o.regs_rddata1 = fwd_rddata[1];
        end
        pipe_id_n_o.decode_resp = decoder_resp;
        pipe_id_n_o.delayslot = delayslot;
        pipe_id_n_o.inst_fetch = pipe_if_i;
        // load/store effective address
        pipe_id_n_o.mem_vaddr = fwd_rddata[0] + imm_sext;
    end

    assign ready_o = ready_i && !load_stall;

    // a stall registers a bubble, back-pressure holds
    always_ff @(posedge clk) begin
        if (rst || except_req_i.valid) begin
            pipe_id_o <= '0;
        end else if (ready_i) begin
            pipe_id_o <= pipe_id_n_o;
        end
    end

    // flush empties the output and the delay slot tracker alike
    a_flush_clears_id: assert property (
        @(posedge clk) disable iff (rst)
        except_req_i.valid |=> !pipe_id_o.valid && !pipe_id_n_o.delayslot
    ) else $error("pipe_id still valid or slot flagged after flush");

endmodule

// ==== verilog/regfile.sv ====
// general purpose register file
`timescale 1ns/1ps

module regfile (
    input  logic                      clk,
    input  logic                      rst,
    input  id_pkg::regs_wreq_t        regs_wreq_i,
    input  id_pkg::reg_addr_t   [1:0] regs_raddr_i,
    output id_pkg::uint32_t     [1:0] regs_rddata_o
);
    import id_pkg::*;

    uint32_t regs [32];

    // single write port, r0 never written
    always_ff @(posedge clk) begin
        if (regs_wreq_i.we && regs_wreq_i.waddr != '0) begin
            regs[regs_wreq_i.waddr] <= regs_wreq_i.wrdata;
        end
    end

    // asynchronous reads
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            if (regs_raddr_i[i] == '0) begin
                regs_rddata_o[i] = '0;
            end else begin
                regs_rddata_o[i] = regs[regs_raddr_i[i]];
            end
        end
    end

    // a write aimed at r0 must leave it reading zero
    a_r0_stays_zero: assert property (
        @(posedge clk) disable iff (rst)
        (regs_wreq_i.we && regs_wreq_i.waddr == '0)
        |=> ((regs_raddr_i[0] != '0 || regs_rddata_o[0] == '0)
            && (regs_raddr_i[1] != '0 || regs_rddata_o[1] == '0))
    ) else $error("r0 read nonzero after write to r0");

endmodule

// ==== verilog/regs_forward.sv ====
// operand bypass and load-use detect
`timescale 1ns/1ps

module regs_forward (
    input  id_pkg::reg_addr_t [1:0] regs_raddr_i,
    input  id_pkg::uint32_t   [1:0] regs_rddata_i,
    input  id_pkg::pipe_ex_t        pipe_ex_i,
    input  id_pkg::pipe_wb_t        pipe_wb_i,
    output id_pkg::uint32_t   [1:0] regs_rddata_o,
    output logic                    stall_o
);

    logic [1:0] ex_hit;
    logic [1:0] wb_hit;

    // per-port match against the in-flight writers
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            ex_hit[i] = pipe_ex_i.regs_wreq.we
                && pipe_ex_i.regs_wreq.waddr == regs_raddr_i[i];
            wb_hit[i] = pipe_wb_i.regs_wreq.we
                && pipe_wb_i.regs_wreq.waddr == regs_raddr_i[i];
        end
    end

    // execute beats write-back, r0 beats both
    always_comb begin
        stall_o = 1'b0;
        for (int i = 0; i < 2; i++) begin
            if (regs_raddr_i[i] == '0) begin
                regs_rddata_o[i] = '0;
            end else if (ex_hit[i]) begin
                regs_rddata_o[i] = pipe_ex_i.regs_wreq.wrdata;
                // load data not back yet
                if (pipe_ex_i.is_load) begin
                    stall_o = 1'b1;
                end
            end else if (wb_hit[i]) begin
                regs_rddata_o[i] = pipe_wb_i.regs_wreq.wrdata;
            end else begin
                regs_rddata_o[i] = regs_rddata_i[i];
            end
        end
    end

    // only a load in execute aimed at a real register may hold the stage
    always_comb begin
        a_stall_needs_load: assert final (!stall_o
            || (pipe_ex_i.is_load && pipe_ex_i.regs_wreq.we
                && pipe_ex_i.regs_wreq.waddr != '0))
            else $error("stall without a register load in execute");
    end

endmodule

// ==== verilog/resolve_delayslot.sv ====
// branch delay slot tracker
`timescale 1ns/1ps

module resolve_delayslot (
    input  logic clk,
    input  logic rst,
    input  logic flush_i,
    input  logic stall_i,
    input  logic issue_valid_i,
    input  logic is_branch_i,
    output logic delayslot_o
);

    typedef enum logic {
        IDLE,
        IN_SLOT
    } ds_state_t;

    ds_state_t state_q;

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            state_q <= IDLE;
        end else if (!stall_i && issue_valid_i) begin
            case (state_q)
                IDLE:    state_q <= is_branch_i ? IN_SLOT : IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    // the first valid issue after a branch
    assign delayslot_o = (state_q == IN_SLOT) && issue_valid_i;

    // once the slot issues the machine is idle and flags nothing
    a_slot_single_issue: assert property (
        @(posedge clk) disable iff (rst)
        (delayslot_o && !stall_i) |=> !delayslot_o
    ) else $error("delay slot flagged on two issues in a row");

endmodule
